/* src/z80_bus_defines.svh */
`ifndef Z80_BUS_DEFINES_SVH
`define Z80_BUS_DEFINES_SVH

// Bus widths
`define ADDR_W          16
`define DATA_W          8
`define PAGE_W          6
`define BA_W            5
`define KEYS_W          64

// Keyboard buffer entries
`define KBBUF_DEPTH     16

// Bank register reset values {ro, overlay, page}
`define BANK0_RESET     8'hC0   // Overlay and read-only, page 0
`define BANK1_RESET     8'd33
`define BANK2_RESET     8'd34
`define BANK3_RESET     8'd19

// Page map
`define SYSRAM_PAGE     32
`define CART_FIRST      16
`define CART_LAST       19
`define RAM_FIRST       32

`endif

/* src/z80_bus_pkg.sv */
`include "z80_bus_defines.svh"

package z80_bus_pkg;

    ////////////////////////////////////////
    // Bank register layout
    ////////////////////////////////////////
    typedef struct packed {
        logic                 ro;       // Block memory writes
        logic                 overlay;  // Enable $3000-$3FFF overlay
        logic [`PAGE_W-1:0]   page;
    } bank_reg_t;

    ////////////////////////////////////////
    // IO port map
    ////////////////////////////////////////
    typedef enum logic [7:0] {
        IO_BANK0   = 8'hF0,
        IO_BANK1   = 8'hF1,
        IO_BANK2   = 8'hF2,
        IO_BANK3   = 8'hF3,
        IO_KBBUF   = 8'hFA,     // R pops, W clears
        IO_SYSCTRL = 8'hFB,
        IO_KEYB    = 8'hFF      // Matrix read, rows on A15-A8
    } io_port_e;

endpackage

/* src/cpu_bus_if.sv */
`timescale 1ns/1ps
`include "z80_bus_defines.svh"

// Synchronized CPU bus between strobe sync and decoder
interface cpu_bus_if;
    logic [`ADDR_W-1:0] addr;
    logic               mreq_n;
    logic               iorq_n;
    logic               rd_n;
    logic               wr_n;
    logic [`DATA_W-1:0] wrdata;     // Latched while wr_n low
    logic               rd_pulse;   // One clock per read strobe
    logic               wr_pulse;   // One clock per write strobe

    modport producer (
        output addr,
        output mreq_n,
        output iorq_n,
        output rd_n,
        output wr_n,
        output wrdata,
        output rd_pulse,
        output wr_pulse
    );

    modport consumer (
        input addr,
        input mreq_n,
        input iorq_n,
        input rd_n,
        input wr_n,
        input wrdata,
        input rd_pulse,
        input wr_pulse
    );
endinterface

/* src/bus_strobe_sync.sv */
`timescale 1ns/1ps
`include "z80_bus_defines.svh"

module bus_strobe_sync (
    input  logic               clk,
    input  logic               reset,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`DATA_W-1:0] d_in,
    input  logic               rd_n,
    input  logic               wr_n,
    input  logic               mreq_n,
    input  logic               iorq_n,
    cpu_bus_if.producer        bus
);

    // Bit 1 is rd_n, bit 0 is wr_n
    logic [2:0][1:0]    strb_sr;
    logic [1:0]         pulse_q;
    logic [`DATA_W-1:0] wrdata_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            strb_sr <= '1;      // Strobes idle high
            pulse_q <= '0;
        end else begin
            strb_sr <= {strb_sr[1:0], {rd_n, wr_n}};
            pulse_q <= strb_sr[2] & ~strb_sr[1];  // Falling edge, once per strobe
        end
    end

    // Write data follows the bus for as long as the strobe is low
    always_ff @(posedge clk) begin
        if (!wr_n)
            wrdata_q <= d_in;
    end

    // Raw address and strobes feed the combinational decode
    assign bus.addr     = addr;
    assign bus.mreq_n   = mreq_n;
    assign bus.iorq_n   = iorq_n;
    assign bus.rd_n     = rd_n;
    assign bus.wr_n     = wr_n;
    assign bus.wrdata   = wrdata_q;
    assign bus.rd_pulse = pulse_q[1];
    assign bus.wr_pulse = pulse_q[0];

endmodule

/* src/key_fifo.sv */
`timescale 1ns/1ps
`include "z80_bus_defines.svh"

module key_fifo (
    input  logic               clk,
    input  logic               reset,
    input  logic [`DATA_W-1:0] push_data,
    input  logic               push,
    input  logic               pop,
    input  logic               clear,
    output logic [`DATA_W-1:0] head
);

    localparam int DEPTH = `KBBUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [`DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               empty;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (PTR_W+1)'(DEPTH));
    assign do_push = push && !full;     // Keys arriving while full are lost
    assign do_pop  = pop && !empty;

    ////////////////////////////////////////
    // Pointers and fill level
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at DEPTH
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push && !clear)
            mem[wr_ptr] <= push_data;
    end

    assign head = empty ? '0 : mem[rd_ptr];

endmodule

/* src/io_mem_decode.sv */
`timescale 1ns/1ps
`include "z80_bus_defines.svh"

module io_mem_decode (
    cpu_bus_if.consumer        bus,
    input  logic               clk,
    input  logic               reset,
    input  logic [`KEYS_W-1:0] keys,
    input  logic [`DATA_W-1:0] kb_data,
    output logic               kb_pop,
    output logic               kb_clear,
    output logic [`DATA_W-1:0] d_out,
    output logic               d_oe,
    output logic [`BA_W-1:0]   ba,
    output logic               ram_ce_n,
    output logic               cart_ce_n,
    output logic               ram_we_n,
    output logic               turbo
);

    import z80_bus_pkg::*;

    localparam logic [7:0]         BANK_BASE   = IO_BANK0;
    localparam logic [`PAGE_W-1:0] SYSRAM_PG   = `SYSRAM_PAGE;
    localparam logic [`PAGE_W-1:0] CART_LO     = `CART_FIRST;
    localparam logic [`PAGE_W-1:0] CART_HI     = `CART_LAST;
    localparam logic [`PAGE_W-1:0] RAM_LO      = `RAM_FIRST;

    bank_reg_t          bank_r [4];
    logic               dis_regs_r;
    logic               turbo_r;

    bank_reg_t          bank;
    logic [7:0]         io_addr;
    logic               sel_io_bank;
    logic               sel_io_kbbuf;
    logic               sel_io_sysctrl;
    logic               sel_io_keyb;
    logic               sel_internal;
    logic               sel_ovl_hole;
    logic               sel_sysram;
    logic               allow_mem;
    logic               sel_cart;
    logic               sel_ram;
    logic [`DATA_W-1:0] key_rows;
    logic [`DATA_W-1:0] rd_data;

    ////////////////////////////////////////
    // Memory decode
    ////////////////////////////////////////
    assign bank = bank_r[bus.addr[15:14]];  // A15-A14 pick the bank

    // $3000-$37FF was TRAM, nothing answers there now
    assign sel_ovl_hole = !bus.mreq_n && bank.overlay && bus.addr[13:11] == 3'b110;
    assign sel_sysram   = !bus.mreq_n && bank.overlay && bus.addr[13:11] == 3'b111;

    assign allow_mem = !bus.mreq_n && !sel_ovl_hole && !sel_sysram &&
                       (bus.wr_n || !bank.ro);

    assign sel_cart = allow_mem && bank.page >= CART_LO && bank.page <= CART_HI;
    assign sel_ram  = (allow_mem && bank.page >= RAM_LO) || sel_sysram;

    assign ba        = sel_sysram ? SYSRAM_PG[`BA_W-1:0] : bank.page[`BA_W-1:0];
    assign ram_ce_n  = !sel_ram;
    assign cart_ce_n = !sel_cart;
    assign ram_we_n  = !(!bus.wr_n && (sel_sysram || (sel_ram && !bank.ro)));

    ////////////////////////////////////////
    // IO decode
    ////////////////////////////////////////
    assign io_addr = bus.addr[7:0];

    // Bank registers vanish while dis_regs is set
    assign sel_io_bank    = !dis_regs_r && !bus.iorq_n && io_addr[7:2] == BANK_BASE[7:2];
    assign sel_io_kbbuf   = !bus.iorq_n && io_addr == IO_KBBUF;
    assign sel_io_sysctrl = !bus.iorq_n && io_addr == IO_SYSCTRL;
    assign sel_io_keyb    = !bus.iorq_n && io_addr == IO_KEYB;

    assign sel_internal = sel_io_bank | sel_io_kbbuf | sel_io_sysctrl | sel_io_keyb;

    assign kb_pop   = sel_io_kbbuf && bus.rd_pulse;
    assign kb_clear = sel_io_kbbuf && bus.wr_pulse;

    ////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank_r[0]  <= bank_reg_t'(`BANK0_RESET);
            bank_r[1]  <= bank_reg_t'(`BANK1_RESET);
            bank_r[2]  <= bank_reg_t'(`BANK2_RESET);
            bank_r[3]  <= bank_reg_t'(`BANK3_RESET);
            dis_regs_r <= 1'b0;
            turbo_r    <= 1'b0;
        end else if (bus.wr_pulse) begin
            if (sel_io_bank)
                bank_r[io_addr[1:0]] <= bank_reg_t'(bus.wrdata);
            if (sel_io_sysctrl) begin
                dis_regs_r <= bus.wrdata[0];
                turbo_r    <= bus.wrdata[2];    // Bit 1 unused
            end
        end
    end

    assign turbo = turbo_r;

    // Matrix read, AND of every row whose address line is low
    always_comb begin
        key_rows = '1;
        for (int r = 0; r < 8; r++) begin
            if (!bus.addr[8 + r])
                key_rows = key_rows & keys[r*8 +: 8];
        end
    end

    ////////////////////////////////////////
    // Read data
    ////////////////////////////////////////
    always_comb begin
        rd_data = '0;
        if (sel_io_bank)
            rd_data = bank_r[io_addr[1:0]];                 // IO $F0-$F3
        if (sel_io_kbbuf)
            rd_data = kb_data;                              // IO $FA
        if (sel_io_sysctrl)
            rd_data = {5'b0, turbo_r, 1'b0, dis_regs_r};    // IO $FB
        if (sel_io_keyb)
            rd_data = key_rows;                             // IO $FF
    end

    assign d_out = rd_data;
    assign d_oe  = !bus.rd_n && sel_internal;

endmodule

/* src/z80_bus_top.sv */
`timescale 1ns/1ps
`include "z80_bus_defines.svh"

module z80_bus_top (
    input  logic               clk,
    input  logic               reset,

    // CPU bus
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`DATA_W-1:0] d_in,
    output logic [`DATA_W-1:0] d_out,
    output logic               d_oe,        // Drive d_out onto the bus
    input  logic               rd_n,
    input  logic               wr_n,
    input  logic               mreq_n,
    input  logic               iorq_n,

    // External memory
    output logic [`BA_W-1:0]   ba,
    output logic               ram_ce_n,
    output logic               cart_ce_n,
    output logic               ram_we_n,

    // Keyboard
    input  logic [`KEYS_W-1:0] keys,
    input  logic [`DATA_W-1:0] key_code,
    input  logic               key_valid,

    output logic               turbo
);

    logic [`DATA_W-1:0] kb_data;
    logic               kb_pop;
    logic               kb_clear;

    cpu_bus_if bus_if ();

    ////////////////////////////////////////
    // Strobe sync, bus producer
    ////////////////////////////////////////
    bus_strobe_sync u_sync (
        .clk    (clk),
        .reset  (reset),
        .addr   (addr),
        .d_in   (d_in),
        .rd_n   (rd_n),
        .wr_n   (wr_n),
        .mreq_n (mreq_n),
        .iorq_n (iorq_n),
        .bus    (bus_if)
    );

    // Key code buffer
    key_fifo u_kbbuf (
        .clk       (clk),
        .reset     (reset),
        .push_data (key_code),
        .push      (key_valid),
        .pop       (kb_pop),
        .clear     (kb_clear),
        .head      (kb_data)
    );

    ////////////////////////////////////////
    // Decoder, bus consumer
    ////////////////////////////////////////
    io_mem_decode u_decode (
        .bus       (bus_if),
        .clk       (clk),
        .reset     (reset),
        .keys      (keys),
        .kb_data   (kb_data),
        .kb_pop    (kb_pop),
        .kb_clear  (kb_clear),
        .d_out     (d_out),
        .d_oe      (d_oe),
        .ba        (ba),
        .ram_ce_n  (ram_ce_n),
        .cart_ce_n (cart_ce_n),
        .ram_we_n  (ram_we_n),
        .turbo     (turbo)
    );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;    // Released just after the edge
    end

endmodule

/* dv/z80_bus_chk.sv */
`timescale 1ns/1ps

module z80_bus_chk (
    input logic clk,
    input logic reset,
    input logic ram_ce_n,
    input logic cart_ce_n,
    input logic kb_pop,
    input logic kb_clear,
    input logic d_oe,
    input logic rd_n
);

    int unsigned fail_count;

    initial fail_count = 0;

    ////////////////////////////////////////
    // Bus safety properties
    ////////////////////////////////////////
    a_one_chip: assert property (@(posedge clk) disable iff (reset) ram_ce_n || cart_ce_n)
        else begin
            fail_count++;
            $error("RAM and cartridge chip enables low together");
        end

    // Pop comes from a read, clear from a write
    a_pop_clear: assert property (@(posedge clk) disable iff (reset) !(kb_pop && kb_clear))
        else begin
            fail_count++;
            $error("Key buffer pop and clear in the same cycle");
        end

    a_oe_read: assert property (@(posedge clk) disable iff (reset) rd_n |-> !d_oe)
        else begin
            fail_count++;
            $error("d_oe high without a read strobe");
        end

endmodule

/* dv/z80_bus_tb.sv */
`timescale 1ns/1ps
`include "z80_bus_defines.svh"

module z80_bus_tb;
    import z80_bus_pkg::*;

    localparam int HOLD_CYCLES = 6;
    localparam int IDLE_CYCLES = 2;
    localparam int BUS_CYCLES  = 28 + 66 + 7 + 16 + 26 + 16;   // Tests 1 to 6
    localparam int TIMEOUT     = BUS_CYCLES * (HOLD_CYCLES + IDLE_CYCLES) + 200;
    localparam logic [7:0]         BANK_PORT = IO_BANK0;
    localparam logic [`PAGE_W-1:0] SYSRAM_PG = `SYSRAM_PAGE;

    logic               clk;
    logic               reset;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] d_in;
    logic [`DATA_W-1:0] d_out;
    logic               d_oe;
    logic               rd_n;
    logic               wr_n;
    logic               mreq_n;
    logic               iorq_n;
    logic [`BA_W-1:0]   ba;
    logic               ram_ce_n;
    logic               cart_ce_n;
    logic               ram_we_n;
    logic [`KEYS_W-1:0] keys;
    logic [`DATA_W-1:0] key_code;
    logic               key_valid;
    logic               turbo;

    // Reference model
    bank_reg_t          bank_m [4];
    logic               dis_m;
    logic               turbo_m;
    logic [7:0]         kbq [$];

    // Outputs captured one cycle into the strobe
    logic [`DATA_W-1:0] s_d_out;
    logic               s_d_oe;
    logic [`BA_W-1:0]   s_ba;
    logic               s_ram_ce_n;
    logic               s_cart_ce_n;
    logic               s_ram_we_n;

    logic [31:0]        lfsr;
    int                 errors;
    int                 test_errs;
    int                 tests_failed;
    int                 cycle_count;
    int unsigned        assert_fails;

    tb_clk_gen u_clk (.clk(clk), .reset(reset));

    z80_bus_top DUT (
        .clk(clk), .reset(reset), .addr(addr), .d_in(d_in), .d_out(d_out), .d_oe(d_oe),
        .rd_n(rd_n), .wr_n(wr_n), .mreq_n(mreq_n), .iorq_n(iorq_n), .ba(ba),
        .ram_ce_n(ram_ce_n), .cart_ce_n(cart_ce_n), .ram_we_n(ram_we_n), .keys(keys),
        .key_code(key_code), .key_valid(key_valid), .turbo(turbo)
    );

    bind io_mem_decode z80_bus_chk u_chk (
        .clk(clk), .reset(reset), .ram_ce_n(ram_ce_n), .cart_ce_n(cart_ce_n),
        .kb_pop(kb_pop), .kb_clear(kb_clear), .d_oe(d_oe), .rd_n(bus.rd_n)
    );

    always @(posedge clk or posedge reset) begin
        if (reset)
            cycle_count <= 0;
        else
            cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT);
        $display("Timed out after %0d clock cycles, the tests did not finish", cycle_count);
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    // Galois LFSR stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        $display("%-28s %s, %0d errors", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
        errors += test_errs;
        if (test_errs != 0)
            tests_failed++;
        test_errs = 0;
    endtask

    // Strobe low for HOLD_CYCLES then idle
    // Starts and ends on a rising edge
    task automatic bus_cycle(input logic is_io, input logic is_wr, input logic [15:0] a,
                             input logic [7:0] wdata);
        #2;
        addr   = a;
        d_in   = wdata;
        mreq_n = is_io;
        iorq_n = !is_io;
        rd_n   = is_wr;
        wr_n   = !is_wr;
        @(posedge clk);
        @(negedge clk);
        s_d_out     = d_out;
        s_d_oe      = d_oe;
        s_ba        = ba;
        s_ram_ce_n  = ram_ce_n;
        s_cart_ce_n = cart_ce_n;
        s_ram_we_n  = ram_we_n;
        repeat (HOLD_CYCLES - 1) @(posedge clk);
        #2;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        bus_cycle(1'b1, 1'b1, {8'h00, port}, data);
        if (!dis_m && port >= IO_BANK0 && port <= IO_BANK3)
            bank_m[port[1:0]] = bank_reg_t'(data);
        else if (port == IO_SYSCTRL) begin
            dis_m   = data[0];
            turbo_m = data[2];
        end else if (port == IO_KBBUF)
            kbq.delete();
    endtask

    // Returns {d_oe, d_out} for an IO read
    function automatic logic [8:0] io_read_expect(input logic [15:0] a);
        logic [7:0] port;
        logic [7:0] rows;
        port = a[7:0];
        rows = 8'hFF;
        if (!dis_m && port >= IO_BANK0 && port <= IO_BANK3)
            return {1'b1, bank_m[port[1:0]]};
        if (port == IO_KBBUF)
            return {1'b1, (kbq.size() > 0) ? kbq[0] : 8'h00};
        if (port == IO_SYSCTRL)
            return {1'b1, 5'b0, turbo_m, 1'b0, dis_m};
        if (port == IO_KEYB) begin
            for (int r = 0; r < 8; r++)
                if (!a[8 + r])
                    rows = rows & keys[r*8 +: 8];   // Row selected by a low line
            return {1'b1, rows};
        end
        return 9'h000;
    endfunction

    task automatic io_read(input logic [15:0] a);
        logic [8:0] exp;
        exp = io_read_expect(a);
        bus_cycle(1'b1, 1'b0, a, 8'h00);
        check("d_oe", 64'(s_d_oe), 64'(exp[8]));
        if (exp[8])
            check("d_out", 64'(s_d_out), 64'(exp[7:0]));
        if (a[7:0] == IO_KBBUF && kbq.size() > 0)
            void'(kbq.pop_front());
    endtask

    task automatic mem_access(input logic is_wr, input logic [15:0] a);
        bank_reg_t  b;
        logic       exp_ram_n;
        logic       exp_cart_n;
        logic       exp_we_n;
        logic [4:0] exp_ba;
        b          = bank_m[a[15:14]];
        exp_ram_n  = 1'b1;
        exp_cart_n = 1'b1;
        exp_we_n   = 1'b1;
        exp_ba     = b.page[`BA_W-1:0];
        if (b.overlay && a[13:11] == 3'b111) begin
            exp_ram_n = 1'b0;           // System RAM stays writable in a read-only bank
            exp_we_n  = !is_wr;
            exp_ba    = SYSRAM_PG[`BA_W-1:0];
        end else if (!(b.overlay && a[13:11] == 3'b110) && !(is_wr && b.ro)) begin
            if (b.page >= `RAM_FIRST) begin
                exp_ram_n = 1'b0;
                exp_we_n  = !is_wr;
            end else if (b.page >= `CART_FIRST && b.page <= `CART_LAST)
                exp_cart_n = 1'b0;
        end
        bus_cycle(1'b0, is_wr, a, 8'(rand_bits(8)));
        check("ram_ce_n", 64'(s_ram_ce_n), 64'(exp_ram_n));
        check("cart_ce_n", 64'(s_cart_ce_n), 64'(exp_cart_n));
        check("ram_we_n", 64'(s_ram_we_n), 64'(exp_we_n));
        if (!exp_ram_n || !exp_cart_n)
            check("ba", 64'(s_ba), 64'(exp_ba));
    endtask

    task automatic push_key(input logic [7:0] c);
        #2;
        key_code  = c;
        key_valid = 1'b1;
        @(posedge clk);
        #2;
        key_valid = 1'b0;
        if (kbq.size() < `KBBUF_DEPTH)
            kbq.push_back(c);
        @(posedge clk);
    endtask

    task automatic set_keys(input logic [63:0] v);
        #2;
        keys = v;
        @(posedge clk);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    initial begin
        logic [1:0] idx;
        logic [7:0] row_sel;
        int         unmapped [3];
        lfsr         = 32'd75656;
        unmapped     = '{3, 20, 21};
        errors       = 0;
        test_errs    = 0;
        tests_failed = 0;
        addr         = '0;
        d_in         = '0;
        rd_n         = 1'b1;
        wr_n         = 1'b1;
        mreq_n       = 1'b1;
        iorq_n       = 1'b1;
        keys         = '1;
        key_code     = '0;
        key_valid    = 1'b0;
        bank_m[0]    = bank_reg_t'(`BANK0_RESET);
        bank_m[1]    = bank_reg_t'(`BANK1_RESET);
        bank_m[2]    = bank_reg_t'(`BANK2_RESET);
        bank_m[3]    = bank_reg_t'(`BANK3_RESET);
        dis_m        = 1'b0;
        turbo_m      = 1'b0;
        @(negedge reset);
        @(posedge clk);

        for (int i = 0; i < 4; i++)
            io_read({8'h00, BANK_PORT[7:2], 2'(i)});
        repeat (3) begin
            for (int i = 0; i < 4; i++)
                io_write({BANK_PORT[7:2], 2'(i)}, 8'(rand_bits(8)));
            for (int i = 0; i < 4; i++)
                io_read({8'h00, BANK_PORT[7:2], 2'(i)});
        end
        end_test("bank registers");

        for (int k = 0; k < 12; k++) begin
            idx = 2'(rand_bits(2));
            io_write({BANK_PORT[7:2], idx}, 8'(rand_bits(8)));
            repeat (4) mem_access(1'(rand_bits(1)), {idx, 14'(rand_bits(14))});
        end
        foreach (unmapped[j]) begin
            io_write(IO_BANK1, {2'b00, 6'(unmapped[j])});
            mem_access(1'b0, {2'b01, 14'(rand_bits(14))});
        end
        end_test("memory decode");

        io_write(IO_BANK2, {1'b1, 1'b0, 6'd40});    // Read-only RAM page
        mem_access(1'b1, {2'b10, 14'(rand_bits(14))});
        mem_access(1'b0, {2'b10, 14'(rand_bits(14))});
        io_write(IO_BANK0, {1'b1, 1'b1, 6'd33});    // Read-only RAM page with overlay
        mem_access(1'b1, {5'b00111, 11'(rand_bits(11))});
        mem_access(1'b0, {5'b00110, 11'(rand_bits(11))});
        mem_access(1'b1, {5'b00000, 11'(rand_bits(11))});
        end_test("write protect and overlay");

        repeat (4) begin
            io_write(IO_SYSCTRL, 8'(rand_bits(8)));
            check("turbo", 64'(turbo), 64'(turbo_m));
            io_read({8'h00, IO_SYSCTRL});
        end
        io_write(IO_SYSCTRL, 8'h01);
        for (int i = 0; i < 4; i++)
            io_read({8'h00, BANK_PORT[7:2], 2'(i)});
        io_write(IO_BANK1, 8'(rand_bits(8)));        // Hidden while registers are disabled
        io_write(IO_SYSCTRL, 8'h00);
        io_read({8'h00, IO_BANK1});
        end_test("system control");

        io_write(IO_KBBUF, 8'h00);
        repeat (5) push_key(8'(rand_bits(8)));
        repeat (6) io_read({8'h00, IO_KBBUF});
        repeat (20) push_key(8'(rand_bits(8)));
        repeat (17) io_read({8'h00, IO_KBBUF});
        repeat (3) push_key(8'(rand_bits(8)));
        io_write(IO_KBBUF, 8'h00);
        io_read({8'h00, IO_KBBUF});
        end_test("key buffer");

        for (int i = 0; i < 16; i++) begin
            set_keys(rand_bits(64));
            row_sel = (i == 15) ? 8'hFF : 8'(rand_bits(8));
            io_read({row_sel, IO_KEYB});
        end
        end_test("keyboard matrix");

        assert_fails = DUT.u_decode.u_chk.fail_count;
        if (assert_fails != 0)
            $display("Bound assertions failed %0d times", assert_fails);
        $display("Tests run 6, failed %0d, check errors %0d", tests_failed, errors);
        if (errors == 0 && assert_fails == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+src
src/z80_bus_pkg.sv
src/cpu_bus_if.sv
src/bus_strobe_sync.sv
src/key_fifo.sv
src/io_mem_decode.sv
src/z80_bus_top.sv
dv/tb_clk_gen.sv
dv/z80_bus_chk.sv
dv/z80_bus_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= z80_bus_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
